// ==== verilog/apb_bridge_cfg.svh ====
// bus widths and register bank size for the APB bridge, included wherever sizes are needed
`ifndef APB_BRIDGE_CFG_SVH
`define APB_BRIDGE_CFG_SVH

// byte address width on both sides
`define APB_ADDR_W 8

// requester side data width
`define APB_S_DATA_W 32

// completer side data width, must divide the requester width
`define APB_M_DATA_W 16

// halfword registers in the bank, 64 bytes in all
`define APB_REG_COUNT 32

`endif

// ==== verilog/apb_bridge_pkg.sv ====
// shared vector types and the adapter FSM encoding for the APB bridge design
`include "apb_bridge_cfg.svh"

package apb_bridge_pkg;

    // byte address, same on both sides
    typedef logic [`APB_ADDR_W-1:0] addr_t;

    // requester side
    typedef logic [`APB_S_DATA_W-1:0] s_data_t;
    typedef logic [`APB_S_DATA_W/8-1:0] s_strb_t;

    // completer side
    typedef logic [`APB_M_DATA_W-1:0] m_data_t;
    typedef logic [`APB_M_DATA_W/8-1:0] m_strb_t;

    typedef enum logic {
        st_idle,
        st_data
    } adapter_state_t;

endpackage

// ==== verilog/apb_width_adapter.sv ====
// APB to APB width adapter, passes through at equal widths and splits wide transfers otherwise
`include "apb_bridge_cfg.svh"

module apb_width_adapter #(
    parameter int S_DATA_W = `APB_S_DATA_W,
    parameter int M_DATA_W = `APB_M_DATA_W
) (
    input  logic                    clk,
    input  logic                    rst,

    // requester side
    input  apb_bridge_pkg::addr_t   s_paddr,
    input  logic                    s_psel,
    input  logic                    s_penable,
    input  logic                    s_pwrite,
    input  apb_bridge_pkg::s_data_t s_pwdata,
    input  apb_bridge_pkg::s_strb_t s_pstrb,
    output logic                    s_pready,
    output apb_bridge_pkg::s_data_t s_prdata,
    output logic                    s_pslverr,

    // completer side
    output apb_bridge_pkg::addr_t   m_paddr,
    output logic                    m_psel,
    output logic                    m_penable,
    output logic                    m_pwrite,
    output apb_bridge_pkg::m_data_t m_pwdata,
    output apb_bridge_pkg::m_strb_t m_pstrb,
    input  logic                    m_pready,
    input  apb_bridge_pkg::m_data_t m_prdata,
    input  logic                    m_pslverr
);
    import apb_bridge_pkg::*;

    if (S_DATA_W < M_DATA_W) begin : g_upsize_check
        $fatal(1, "apb_width_adapter: upsizing is not supported");
    end

    if (S_DATA_W % M_DATA_W != 0) begin : g_ratio_check
        $fatal(1, "apb_width_adapter: widths must divide evenly");
    end

    if (S_DATA_W != $bits(s_data_t) || M_DATA_W != $bits(m_data_t)) begin : g_type_check
        $fatal(1, "apb_width_adapter: parameters disagree with the bus types");
    end

    if (S_DATA_W == M_DATA_W) begin : g_bypass
        // same width, straight through
        assign m_paddr   = s_paddr;
        assign m_psel    = s_psel;
        assign m_penable = s_penable;
        assign m_pwrite  = s_pwrite;
        assign m_pwdata  = s_pwdata;
        assign m_pstrb   = s_pstrb;
        assign s_pready  = m_pready;
        assign s_prdata  = m_prdata;
        assign s_pslverr = m_pslverr;
    end else if (S_DATA_W > M_DATA_W) begin : g_downsize
        localparam int SEG_COUNT = S_DATA_W / M_DATA_W;
        localparam int SEG_W = $clog2(SEG_COUNT);
        localparam int M_STRB_W = M_DATA_W / 8;
        // clears the byte offset within a requester word
        localparam addr_t S_ADDR_MASK = ~addr_t'(S_DATA_W / 8 - 1);

        adapter_state_t   state;
        logic [SEG_W-1:0] seg;
        logic [SEG_W-1:0] seg_next;
        s_data_t          wdata_q;
        s_strb_t          wstrb_q;
        logic             pready_q;
        s_data_t          prdata_q;
        logic             pslverr_q;
        addr_t            paddr_q;
        logic             psel_q;
        logic             penable_q;
        logic             pwrite_q;
        m_data_t          pwdata_q;
        m_strb_t          pstrb_q;

        assign seg_next = seg + SEG_W'(1);

        always_ff @(posedge clk) begin
            pready_q <= 1'b0;
            case (state)
                st_idle: begin
                    // first requester access cycle starts the split
                    if (s_psel && s_penable && !pready_q) begin
                        wdata_q   <= s_pwdata;
                        wstrb_q   <= s_pstrb;
                        seg       <= '0;
                        paddr_q   <= s_paddr & S_ADDR_MASK;
                        pwrite_q  <= s_pwrite;
                        pwdata_q  <= s_pwdata[M_DATA_W-1:0];
                        pstrb_q   <= s_pstrb[M_STRB_W-1:0];
                        pslverr_q <= 1'b0;
                        psel_q    <= 1'b1;
                        state     <= st_data;
                    end
                end
                st_data: begin
                    penable_q <= 1'b1;
                    if (penable_q && m_pready) begin
                        prdata_q[seg*M_DATA_W +: M_DATA_W] <= m_prdata;
                        pslverr_q <= pslverr_q | m_pslverr;
                        penable_q <= 1'b0;
                        if (seg == SEG_W'(SEG_COUNT - 1)) begin
                            psel_q   <= 1'b0;
                            pready_q <= 1'b1;
                            state    <= st_idle;
                        end else begin
                            // psel stays up, next beat begins with its setup cycle
                            seg      <= seg_next;
                            paddr_q  <= paddr_q + addr_t'(M_STRB_W);
                            pwdata_q <= wdata_q[seg_next*M_DATA_W +: M_DATA_W];
                            pstrb_q  <= wstrb_q[seg_next*M_STRB_W +: M_STRB_W];
                        end
                    end
                end
                default: state <= st_idle;
            endcase

            if (rst) begin
                state     <= st_idle;
                seg       <= '0;
                pready_q  <= 1'b0;
                psel_q    <= 1'b0;
                penable_q <= 1'b0;
            end
        end

        assign s_pready  = pready_q;
        assign s_prdata  = prdata_q;
        assign s_pslverr = pslverr_q;
        assign m_paddr   = paddr_q;
        assign m_psel    = psel_q;
        assign m_penable = penable_q;
        assign m_pwrite  = pwrite_q;
        assign m_pwdata  = pwdata_q;
        assign m_pstrb   = pstrb_q;
    end

    a_penable_with_psel: assert property (
        @(posedge clk) disable iff (rst) m_penable |-> m_psel
    ) else $error("m_penable without m_psel");

    // each requester transfer completes with a single ready pulse
    a_pready_pulse: assert property (
        @(posedge clk) disable iff (rst) s_pready |=> !s_pready
    ) else $error("s_pready held for two cycles");

endmodule

// ==== verilog/apb_reg_bank.sv ====
// 16-bit APB register bank with strobed writes, one wait state and an out-of-range error
`include "apb_bridge_cfg.svh"

module apb_reg_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  apb_bridge_pkg::addr_t   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_bridge_pkg::m_data_t pwdata,
    input  apb_bridge_pkg::m_strb_t pstrb,
    output logic                    pready,
    output apb_bridge_pkg::m_data_t prdata,
    output logic                    pslverr
);
    import apb_bridge_pkg::*;

    localparam int LANES = $bits(m_strb_t);
    localparam int IDX_W = $clog2(`APB_REG_COUNT);
    localparam addr_t BANK_BYTES = addr_t'(`APB_REG_COUNT * LANES);

    m_data_t          regs [`APB_REG_COUNT];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             access_first;

    // halfword index, byte offset dropped
    assign idx = paddr[$clog2(LANES) +: IDX_W];
    assign in_range = paddr < BANK_BYTES;

    // pready is registered, so it is still low in the first access cycle
    assign access_first = psel && penable && !pready;

    always_ff @(posedge clk) begin
        pready <= access_first;
        if (access_first) begin
            pslverr <= !in_range;
            prdata  <= (in_range && !pwrite) ? regs[idx] : '0;
            if (in_range && pwrite) begin
                for (int b = 0; b < LANES; b++) begin
                    if (pstrb[b]) begin
                        regs[idx][b*8 +: 8] <= pwdata[b*8 +: 8];
                    end
                end
            end
        end

        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            for (int i = 0; i < `APB_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end
    end

    // requester must hold the access phase until ready
    a_ready_in_access: assert property (
        @(posedge clk) disable iff (rst) pready |-> psel && penable
    ) else $error("pready outside an access phase");

endmodule

// ==== verilog/apb_bridge_top.sv ====
// top level of the APB bridge, a 32-bit requester port reaching the 16-bit register bank
module apb_bridge_top (
    input  logic                    clk,
    input  logic                    rst,
    input  apb_bridge_pkg::addr_t   s_paddr,
    input  logic                    s_psel,
    input  logic                    s_penable,
    input  logic                    s_pwrite,
    input  apb_bridge_pkg::s_data_t s_pwdata,
    input  apb_bridge_pkg::s_strb_t s_pstrb,
    output logic                    s_pready,
    output apb_bridge_pkg::s_data_t s_prdata,
    output logic                    s_pslverr
);
    import apb_bridge_pkg::*;

    // narrow side between adapter and bank
    addr_t   m_paddr;
    logic    m_psel;
    logic    m_penable;
    logic    m_pwrite;
    m_data_t m_pwdata;
    m_strb_t m_pstrb;
    logic    m_pready;
    m_data_t m_prdata;
    logic    m_pslverr;

    apb_width_adapter apb_width_adapter_i (
        .clk       (clk),
        .rst       (rst),
        .s_paddr   (s_paddr),
        .s_psel    (s_psel),
        .s_penable (s_penable),
        .s_pwrite  (s_pwrite),
        .s_pwdata  (s_pwdata),
        .s_pstrb   (s_pstrb),
        .s_pready  (s_pready),
        .s_prdata  (s_prdata),
        .s_pslverr (s_pslverr),
        .m_paddr   (m_paddr),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_pwdata  (m_pwdata),
        .m_pstrb   (m_pstrb),
        .m_pready  (m_pready),
        .m_prdata  (m_prdata),
        .m_pslverr (m_pslverr)
    );

    apb_reg_bank apb_reg_bank_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (m_paddr),
        .psel    (m_psel),
        .penable (m_penable),
        .pwrite  (m_pwrite),
        .pwdata  (m_pwdata),
        .pstrb   (m_pstrb),
        .pready  (m_pready),
        .prdata  (m_prdata),
        .pslverr (m_pslverr)
    );

endmodule

// ==== verification/apb_bridge_checker.sv ====
// requester port monitor for the APB bridge testbench, keeps a byte memory model and counts errors
`include "apb_bridge_cfg.svh"

module apb_bridge_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  apb_bridge_pkg::addr_t   s_paddr,
    input  logic                    s_psel,
    input  logic                    s_penable,
    input  logic                    s_pwrite,
    input  apb_bridge_pkg::s_data_t s_pwdata,
    input  apb_bridge_pkg::s_strb_t s_pstrb,
    input  logic                    s_pready,
    input  apb_bridge_pkg::s_data_t s_prdata,
    input  logic                    s_pslverr,
    output int                      mismatch_count,
    output int                      protocol_count,
    output int                      done_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import apb_bridge_pkg::*;

    localparam int MEM_BYTES = `APB_REG_COUNT * `APB_M_DATA_W / 8;
    // two completer beats of setup plus two access cycles, then the ready cycle
    localparam int ACCESS_CYCLES = 8;

    logic [7:0] mem [MEM_BYTES];
    int         mismatches = 0;
    int         protocol_errors = 0;
    int         done = 0;
    int         access_cycles = 0;
    logic       prev_pready = 1'b0;
    logic       seen_transfer = 1'b0;

    assign mismatch_count = mismatches;
    assign protocol_count = protocol_errors;
    assign done_count     = done;

    task automatic report_mismatch(input string name, input addr_t addr,
                                   input s_data_t expected, input s_data_t actual);
        $display("MISMATCH %s addr=%02h expected=%08h actual=%08h", name, addr, expected, actual);
        mismatches++;
    endtask

    task automatic report_protocol(input string what);
        $display("ERROR at %0t: %s", $time, what);
        protocol_errors++;
    endtask

    always @(posedge clk) begin : watch
        int      base;
        s_data_t expected;
        base = int'(s_paddr);
        if (s_pready === 1'b1 && !seen_transfer) begin
            report_protocol("s_pready high before the first transfer");
        end
        if (rst) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] = 8'h00;
            end
            access_cycles = 0;
            prev_pready = 1'b0;
        end else begin
            if (s_psel) begin
                seen_transfer = 1'b1;
            end
            if (s_pready && prev_pready) begin
                report_protocol("s_pready high for two cycles in a row");
            end
            if (s_pready && !(s_psel && s_penable)) begin
                report_protocol("s_pready high outside an access phase");
            end
            if (s_psel && s_penable) begin
                access_cycles++;
            end
            if (s_psel && s_penable && s_pready) begin
                done++;
                if (access_cycles != ACCESS_CYCLES) begin
                    report_protocol($sformatf("access phase took %0d cycles, expected %0d",
                                              access_cycles, ACCESS_CYCLES));
                end
                access_cycles = 0;
                if (base < MEM_BYTES) begin
                    if (s_pslverr !== 1'b0) begin
                        report_mismatch("pslverr_in_range", s_paddr, 32'd0, {31'd0, s_pslverr});
                    end
                    if (s_pwrite) begin
                        for (int b = 0; b < 4; b++) begin
                            if (s_pstrb[b]) begin
                                mem[base + b] = s_pwdata[b*8 +: 8];
                            end
                        end
                    end else begin
                        // little endian, byte lane n sits at address base + n
                        expected = {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
                        if (s_prdata !== expected) begin
                            report_mismatch("read_data", s_paddr, expected, s_prdata);
                        end
                    end
                end else begin
                    if (s_pslverr !== 1'b1) begin
                        report_mismatch("pslverr_out_of_range", s_paddr, 32'd1,
                                        {31'd0, s_pslverr});
                    end
                    if (!s_pwrite && s_prdata !== 32'd0) begin
                        report_mismatch("read_error_data", s_paddr, 32'd0, s_prdata);
                    end
                end
            end
            prev_pready = s_pready;
        end
    end

endmodule

// ==== verification/apb_bridge_tb.sv ====
// testbench top for the APB bridge, drives random 32-bit transfers and ends on completion or timeout
`include "apb_bridge_cfg.svh"

module apb_bridge_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import apb_bridge_pkg::*;

    localparam int TRANSFER_COUNT = 400;
    // about ten cycles per transfer plus margin
    localparam int TIMEOUT_CYCLES = TRANSFER_COUNT * 10 + 2000;
    localparam int RESET_CYCLES = 5;
    localparam logic [31:0] SEED = 32'h565d7215;

    logic    clk;
    logic    rst;
    addr_t   s_paddr;
    logic    s_psel;
    logic    s_penable;
    logic    s_pwrite;
    s_data_t s_pwdata;
    s_strb_t s_pstrb;
    logic    s_pready;
    s_data_t s_prdata;
    logic    s_pslverr;

    int          mismatch_count;
    int          protocol_count;
    int          done_count;
    int          cycle_count;
    logic [31:0] lfsr;

    apb_bridge_top apb_bridge_top_i (
        .clk       (clk),
        .rst       (rst),
        .s_paddr   (s_paddr),
        .s_psel    (s_psel),
        .s_penable (s_penable),
        .s_pwrite  (s_pwrite),
        .s_pwdata  (s_pwdata),
        .s_pstrb   (s_pstrb),
        .s_pready  (s_pready),
        .s_prdata  (s_prdata),
        .s_pslverr (s_pslverr)
    );

    apb_bridge_checker apb_bridge_checker_i (
        .clk            (clk),
        .rst            (rst),
        .s_paddr        (s_paddr),
        .s_psel         (s_psel),
        .s_penable      (s_penable),
        .s_pwrite       (s_pwrite),
        .s_pwdata       (s_pwdata),
        .s_pstrb        (s_pstrb),
        .s_pready       (s_pready),
        .s_prdata       (s_prdata),
        .s_pslverr      (s_pslverr),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .done_count     (done_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = 32'd0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic do_transfer(input logic write, input addr_t addr,
                               input s_data_t data, input s_strb_t strb);
        s_paddr   = addr;
        s_pwrite  = write;
        s_pwdata  = data;
        s_pstrb   = strb;
        s_psel    = 1'b1;
        s_penable = 1'b0;
        @(posedge clk);
        #2;
        s_penable = 1'b1;
        while (!s_pready) begin
            @(posedge clk);
            #2;
        end
        // hold through the completing edge, then one idle cycle
        @(posedge clk);
        #2;
        s_psel    = 1'b0;
        s_penable = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic print_counts(input int other);
        $display("errors: %0d mismatch, %0d protocol, %0d other",
                 mismatch_count, protocol_count, other);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: timeout after %0d cycles with %0d of %0d transfers done",
                 TIMEOUT_CYCLES, done_count, TRANSFER_COUNT);
        print_counts(1);
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] bits;
        logic        is_write;
        logic [5:0]  word;
        s_data_t     data;
        s_strb_t     strb;
        int          other;
        rst       = 1'b1;
        s_paddr   = '0;
        s_psel    = 1'b0;
        s_penable = 1'b0;
        s_pwrite  = 1'b0;
        s_pwdata  = '0;
        s_pstrb   = '0;
        lfsr      = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int n = 0; n < TRANSFER_COUNT; n++) begin
            draw_bits(1, bits);
            is_write = bits[0];
            draw_bits(3, bits);
            if (bits[2:0] == 3'd0) begin
                // out of range, words 16 to 63
                draw_bits(6, bits);
                word = bits[5:0];
                if (word[5:4] == 2'b00) begin
                    word[4] = 1'b1;
                end
            end else begin
                draw_bits(4, bits);
                word = {2'b00, bits[3:0]};
            end
            draw_bits(32, bits);
            data = bits;
            draw_bits(4, bits);
            strb = is_write ? bits[3:0] : 4'h0;
            do_transfer(is_write, {word, 2'b00}, data, strb);
        end
        repeat (2) @(posedge clk);
        other = 0;
        if (done_count != TRANSFER_COUNT) begin
            $display("ERROR: only %0d of %0d transfers completed", done_count, TRANSFER_COUNT);
            other = 1;
        end
        print_counts(other);
        if (mismatch_count + protocol_count + other == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/apb_bridge_pkg.sv
verilog/apb_width_adapter.sv
verilog/apb_reg_bank.sv
verilog/apb_bridge_top.sv
verification/apb_bridge_checker.sv
verification/apb_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the APB bridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module apb_bridge_tb --Mdir "$BUILD_DIR" -o apb_bridge_sim -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/apb_bridge_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
